// ==== hdl/clear_sync_config.svh ====
// build-time settings of the clear-sequence synchronizer
// the synchronizer depth applies to both req and ack paths of every crossing
// and should not exceed the depth of the crossing that the clear protects
`ifndef CLEAR_SYNC_CONFIG_SVH
`define CLEAR_SYNC_CONFIG_SVH

// ------------------------------------------------------------
// crossing settings
// ------------------------------------------------------------

// number of flip-flops in each req and ack synchronizer, at least 1
`define CLEAR_SYNC_STAGES 2

// level of req and ack while the owning domain is held in reset
`define CLEAR_SYNC_REQ_RESET 1'b0
`define CLEAR_SYNC_ACK_RESET 1'b0

`endif

// ==== hdl/clear_sync_pkg.sv ====
// shared types of the clear-sequence synchronizer
// enum labels carry a prefix because all of them live in the package scope
package clear_sync_pkg;

  // phase of the clear sequence as it is carried to the other domain
  typedef enum logic [1:0] {
    PH_IDLE       = 2'd0,
    PH_ISOLATE    = 2'd1,
    PH_CLEAR      = 2'd2,
    PH_POST_CLEAR = 2'd3
  } clear_phase_e;

  // states of the initiator FSM
  typedef enum logic [2:0] {
    INIT_IDLE,
    INIT_ISOLATE,
    INIT_WAIT_PHASE_ACK,
    INIT_WAIT_ISOLATE_ACK,
    INIT_CLEAR,
    INIT_POST_CLEAR,
    INIT_FINISHED
  } initiator_state_e;

  // forward link of one crossing, the phase is stable while req is high
  typedef struct packed {
    logic         req;
    clear_phase_e phase;
  } phase_link_t;

  // local control levels handed to the user's crossing
  typedef struct packed {
    logic isolate;
    logic clear;
  } clear_ctrl_t;

endpackage

// ==== hdl/phase_cdc_src.sv ====
// source endpoint of the coupled four-phase crossing for one clear phase
// ready pulses only after ack has returned to zero, so no transfer is in flight
// once the user sees it; phase_i must stay stable while phase_valid_i is high
`timescale 1ns/1ps
`include "clear_sync_config.svh"

module phase_cdc_src import clear_sync_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  clear_phase_e phase_i,
  input  logic         phase_valid_i,
  output logic         phase_ready_o,
  output phase_link_t  link_o,
  input  logic         ack_i
);

  localparam int unsigned SYNC_STAGES = `CLEAR_SYNC_STAGES;

  typedef enum logic [1:0] {SRC_IDLE, SRC_REQ, SRC_RTZ} src_state_e;

  src_state_e             state_q, state_d;
  logic                   req_q, req_d;
  clear_phase_e           phase_q;
  logic [SYNC_STAGES-1:0] ack_sync_q;
  logic                   ack_synced;

  // ------------------------------------------------------------
  // ack synchronizer
  // ------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_sync_q <= {SYNC_STAGES{`CLEAR_SYNC_ACK_RESET}};
    end else begin
      ack_sync_q[0] <= ack_i;
      for (int unsigned i = 1; i < SYNC_STAGES; i++) begin
        ack_sync_q[i] <= ack_sync_q[i-1];
      end
    end
  end

  assign ack_synced = ack_sync_q[SYNC_STAGES-1];

  // ------------------------------------------------------------
  // handshake FSM
  // ------------------------------------------------------------

  always_comb begin
    state_d       = state_q;
    req_d         = req_q;
    phase_ready_o = 1'b0;
    case (state_q)
      SRC_IDLE: begin
        // the phase is captured in the same cycle that req is raised
        if (phase_valid_i) begin
          req_d   = 1'b1;
          state_d = SRC_REQ;
        end
      end
      SRC_REQ: begin
        if (ack_synced) begin
          req_d   = 1'b0;
          state_d = SRC_RTZ;
        end
      end
      SRC_RTZ: begin
        // the destination has seen req fall, the round trip is complete
        if (!ack_synced) begin
          phase_ready_o = 1'b1;
          state_d       = SRC_IDLE;
        end
      end
      default: begin
        req_d   = 1'b0;
        state_d = SRC_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SRC_IDLE;
      req_q   <= `CLEAR_SYNC_REQ_RESET;
    end else begin
      state_q <= state_d;
      req_q   <= req_d;
    end
  end

  // payload is only looked at by the destination while req is high
  always_ff @(posedge clk_i) begin
    if (state_q == SRC_IDLE && phase_valid_i) begin
      phase_q <= phase_i;
    end
  end

  // req comes straight from a flop so the link never glitches
  assign link_o.req   = req_q;
  assign link_o.phase = phase_q;

endmodule

// ==== hdl/phase_cdc_dst.sv ====
// destination endpoint of the coupled four-phase crossing
// the received phase is offered until it is accepted, and only then is ack
// raised, which holds the source until this side has taken the phase
`timescale 1ns/1ps
`include "clear_sync_config.svh"

module phase_cdc_dst import clear_sync_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  phase_link_t  link_i,
  output logic         ack_o,
  output clear_phase_e phase_o,
  output logic         phase_valid_o,
  input  logic         phase_ready_i
);

  localparam int unsigned SYNC_STAGES = `CLEAR_SYNC_STAGES;

  typedef enum logic [1:0] {DST_IDLE, DST_VALID, DST_ACK} dst_state_e;

  dst_state_e             state_q, state_d;
  logic                   ack_q, ack_d;
  clear_phase_e           phase_q;
  logic [SYNC_STAGES-1:0] req_sync_q;
  logic                   req_synced;

  // req synchronizer, the phase bits are never synchronized
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_sync_q <= {SYNC_STAGES{`CLEAR_SYNC_REQ_RESET}};
    end else begin
      req_sync_q[0] <= link_i.req;
      for (int unsigned i = 1; i < SYNC_STAGES; i++) begin
        req_sync_q[i] <= req_sync_q[i-1];
      end
    end
  end

  assign req_synced = req_sync_q[SYNC_STAGES-1];

  always_comb begin
    state_d = state_q;
    ack_d   = ack_q;
    case (state_q)
      // ack is low here, so any synced req high is a fresh transfer
      DST_IDLE: if (req_synced) state_d = DST_VALID;
      DST_VALID: begin
        if (phase_ready_i) begin
          ack_d   = 1'b1;
          state_d = DST_ACK;
        end
      end
      DST_ACK: begin
        if (!req_synced) begin
          ack_d   = 1'b0;
          state_d = DST_IDLE;
        end
      end
      default: begin
        ack_d   = 1'b0;
        state_d = DST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DST_IDLE;
      ack_q   <= `CLEAR_SYNC_ACK_RESET;
    end else begin
      state_q <= state_d;
      ack_q   <= ack_d;
    end
  end

  // the phase has long settled once req shows up past the synchronizer
  always_ff @(posedge clk_i) begin
    if (state_q == DST_IDLE && req_synced) begin
      phase_q <= link_i.phase;
    end
  end

  assign ack_o         = ack_q;
  assign phase_o       = phase_q;
  assign phase_valid_o = (state_q == DST_VALID);

endmodule

// ==== hdl/clear_initiator.sv ====
// FSM that steps a locally requested clear through its four phases
// clear_i is only looked at in the idle state, later strobes are ignored
// isolate is held until the closing idle phase is accepted on the far side
`timescale 1ns/1ps

module clear_initiator import clear_sync_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  logic         isolate_ack_i,
  input  logic         phase_ready_i,
  output logic         phase_valid_o,
  output clear_phase_e phase_o,
  output clear_ctrl_t  ctrl_o
);

  initiator_state_e state_q, state_d;

  // ------------------------------------------------------------
  // next state
  // ------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      INIT_IDLE: begin
        if (clear_i) state_d = INIT_ISOLATE;
      end
      INIT_ISOLATE: begin
        // remote acceptance and local acknowledge may come in any order
        if (phase_ready_i && isolate_ack_i) begin
          state_d = INIT_CLEAR;
        end else if (phase_ready_i) begin
          state_d = INIT_WAIT_ISOLATE_ACK;
        end else if (isolate_ack_i) begin
          state_d = INIT_WAIT_PHASE_ACK;
        end
      end
      INIT_WAIT_PHASE_ACK: begin
        if (phase_ready_i) state_d = INIT_CLEAR;
      end
      INIT_WAIT_ISOLATE_ACK: begin
        if (isolate_ack_i) state_d = INIT_CLEAR;
      end
      INIT_CLEAR: begin
        if (phase_ready_i) state_d = INIT_POST_CLEAR;
      end
      INIT_POST_CLEAR: begin
        if (phase_ready_i) state_d = INIT_FINISHED;
      end
      INIT_FINISHED: begin
        if (phase_ready_i) state_d = INIT_IDLE;
      end
      default: state_d = INIT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= INIT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------------------------------------
  // outputs, decoded from the state only
  // ------------------------------------------------------------

  always_comb begin
    phase_valid_o  = 1'b0;
    phase_o        = PH_IDLE;
    ctrl_o.isolate = 1'b0;
    ctrl_o.clear   = 1'b0;
    case (state_q)
      INIT_ISOLATE, INIT_WAIT_PHASE_ACK: begin
        phase_valid_o  = 1'b1;
        phase_o        = PH_ISOLATE;
        ctrl_o.isolate = 1'b1;
      end
      // the isolate phase is already through, only the local ack is missing
      INIT_WAIT_ISOLATE_ACK: begin
        phase_o        = PH_ISOLATE;
        ctrl_o.isolate = 1'b1;
      end
      INIT_CLEAR: begin
        phase_valid_o  = 1'b1;
        phase_o        = PH_CLEAR;
        ctrl_o.isolate = 1'b1;
        ctrl_o.clear   = 1'b1;
      end
      INIT_POST_CLEAR: begin
        phase_valid_o  = 1'b1;
        phase_o        = PH_POST_CLEAR;
        ctrl_o.isolate = 1'b1;
      end
      INIT_FINISHED: begin
        phase_valid_o  = 1'b1;
        phase_o        = PH_IDLE;
        ctrl_o.isolate = 1'b1;
      end
      default: begin
        phase_valid_o = 1'b0;
      end
    endcase
  end

endmodule

// ==== hdl/clear_receiver.sv ====
// mirrors the phases that arrive from the other side onto local isolate/clear
// an offered isolate phase is held back until the local isolate acknowledge
`timescale 1ns/1ps

module clear_receiver import clear_sync_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  clear_phase_e phase_i,
  input  logic         phase_valid_i,
  input  logic         isolate_ack_i,
  output logic         phase_ready_o,
  output clear_ctrl_t  ctrl_o
);

  clear_phase_e phase_q;

  // control levels that belong to one phase
  function automatic clear_ctrl_t phase_to_ctrl(input clear_phase_e phase);
    clear_ctrl_t ctrl;
    ctrl.isolate = 1'b0;
    ctrl.clear   = 1'b0;
    case (phase)
      PH_ISOLATE:    ctrl.isolate = 1'b1;
      PH_CLEAR: begin
        ctrl.isolate = 1'b1;
        ctrl.clear   = 1'b1;
      end
      PH_POST_CLEAR: ctrl.isolate = 1'b1;
      default: begin
        ctrl.isolate = 1'b0;
        ctrl.clear   = 1'b0;
      end
    endcase
    return ctrl;
  endfunction

  // all phases except isolate are taken at once
  always_comb begin
    phase_ready_o = 1'b0;
    if (phase_valid_i) begin
      phase_ready_o = (phase_i != PH_ISOLATE) || isolate_ack_i;
    end
  end

  // an offered phase already drives the outputs before it is accepted,
  // so isolate rises while the acknowledge is still outstanding
  assign ctrl_o = phase_valid_i ? phase_to_ctrl(phase_i) : phase_to_ctrl(phase_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= PH_IDLE;
    end else if (phase_valid_i && phase_ready_o) begin
      phase_q <= phase_i;
    end
  end

endmodule

// ==== hdl/clear_sync_half.sv ====
// one clock domain's half of the clear-sequence synchronizer
// isolate and clear are the OR of the local initiator and the receiver, so
// clears started on both sides at once still follow the phase order
`timescale 1ns/1ps

module clear_sync_half import clear_sync_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  logic        isolate_ack_i,
  output logic        isolate_o,
  output logic        clear_o,
  output phase_link_t link_o,
  input  logic        ack_i,
  input  phase_link_t link_i,
  output logic        ack_o
);

  clear_phase_e init_phase;
  logic         init_valid;
  logic         init_ready;
  clear_ctrl_t  init_ctrl;
  clear_phase_e rx_phase;
  logic         rx_valid;
  logic         rx_ready;
  clear_ctrl_t  rx_ctrl;

  // ------------------------------------------------------------
  // outgoing sequence started in this domain
  // ------------------------------------------------------------

  clear_initiator u_initiator (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .isolate_ack_i (isolate_ack_i),
    .phase_ready_i (init_ready),
    .phase_valid_o (init_valid),
    .phase_o       (init_phase),
    .ctrl_o        (init_ctrl)
  );

  phase_cdc_src u_cdc_src (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .phase_i       (init_phase),
    .phase_valid_i (init_valid),
    .phase_ready_o (init_ready),
    .link_o        (link_o),
    .ack_i         (ack_i)
  );

  // ------------------------------------------------------------
  // incoming sequence started in the other domain
  // ------------------------------------------------------------

  phase_cdc_dst u_cdc_dst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .link_i        (link_i),
    .ack_o         (ack_o),
    .phase_o       (rx_phase),
    .phase_valid_o (rx_valid),
    .phase_ready_i (rx_ready)
  );

  clear_receiver u_receiver (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .phase_i       (rx_phase),
    .phase_valid_i (rx_valid),
    .isolate_ack_i (isolate_ack_i),
    .phase_ready_o (rx_ready),
    .ctrl_o        (rx_ctrl)
  );

  assign isolate_o = init_ctrl.isolate | rx_ctrl.isolate;
  assign clear_o   = init_ctrl.clear | rx_ctrl.clear;

endmodule

// ==== hdl/clear_sync.sv ====
// clear-sequence synchronizer between clock domains a and b
// both sides are symmetric; the user's crossing must stop all traffic while
// isolate_o is high and raise isolate_ack_i once it has done so
// clear_o is meant for a synchronous clear of the crossing's flops
`timescale 1ns/1ps

module clear_sync import clear_sync_pkg::*; (
  input  logic a_clk_i,
  input  logic a_rst_ni,
  input  logic a_clear_i,
  input  logic a_isolate_ack_i,
  output logic a_isolate_o,
  output logic a_clear_o,
  input  logic b_clk_i,
  input  logic b_rst_ni,
  input  logic b_clear_i,
  input  logic b_isolate_ack_i,
  output logic b_isolate_o,
  output logic b_clear_o
);

  // each link is acknowledged by the half that receives it
  phase_link_t a2b_link;
  phase_link_t b2a_link;
  logic        a2b_ack;
  logic        b2a_ack;

  clear_sync_half u_half_a (
    .clk_i         (a_clk_i),
    .rst_ni        (a_rst_ni),
    .clear_i       (a_clear_i),
    .isolate_ack_i (a_isolate_ack_i),
    .isolate_o     (a_isolate_o),
    .clear_o       (a_clear_o),
    .link_o        (a2b_link),
    .ack_i         (a2b_ack),
    .link_i        (b2a_link),
    .ack_o         (b2a_ack)
  );

  clear_sync_half u_half_b (
    .clk_i         (b_clk_i),
    .rst_ni        (b_rst_ni),
    .clear_i       (b_clear_i),
    .isolate_ack_i (b_isolate_ack_i),
    .isolate_o     (b_isolate_o),
    .clear_o       (b_clear_o),
    .link_o        (b2a_link),
    .ack_i         (b2a_ack),
    .link_i        (a2b_link),
    .ack_o         (a2b_ack)
  );

endmodule

// ==== tests/tb_clear_sync.sv ====
// directed testbench for the clear-sequence synchronizer
// clock a runs at 20 ns and clock b at 34 ns, so the edges of the two domains keep drifting
// each side has a responder that raises isolate ack some cycles after isolate rises
// outputs are sampled on the falling edge of their own clock, where they are stable
`timescale 1ns/1ps
`include "clear_sync_config.svh"

module tb_clear_sync;

  // sequence bound in own-clock cycles, with margin for clock ratio and ack delays
  localparam int unsigned MAX_ACK_DELAY = 15;
  localparam int unsigned SEQ_TIMEOUT   = 3 * (20 + 16 * `CLEAR_SYNC_STAGES + 4 * MAX_ACK_DELAY);
  localparam int unsigned HOLD_CYCLES   = 100;
  localparam int unsigned QUIET_CYCLES  = 20;

  logic a_clk, a_rst_n, a_clear_req, a_iso_ack, a_isolate, a_clear;
  logic b_clk, b_rst_n, b_clear_req, b_iso_ack, b_isolate, b_clear;

  logic        a_ack_hold, b_ack_hold;
  int unsigned a_ack_delay, b_ack_delay;
  logic        a_clear_seen, b_clear_seen;
  logic [31:0] lfsr_state;

  clear_sync u_dut (
    .a_clk_i         (a_clk),
    .a_rst_ni        (a_rst_n),
    .a_clear_i       (a_clear_req),
    .a_isolate_ack_i (a_iso_ack),
    .a_isolate_o     (a_isolate),
    .a_clear_o       (a_clear),
    .b_clk_i         (b_clk),
    .b_rst_ni        (b_rst_n),
    .b_clear_i       (b_clear_req),
    .b_isolate_ack_i (b_iso_ack),
    .b_isolate_o     (b_isolate),
    .b_clear_o       (b_clear)
  );

  initial begin
    a_clk = 1'b0;
    forever #10 a_clk = ~a_clk;
  end

  initial begin
    b_clk = 1'b0;
    forever #17 b_clk = ~b_clk;
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // galois LFSR stepped once for every bit handed out
  function automatic logic [31:0] random_bits(input int unsigned nbits);
    logic [31:0] value;
    value = '0;
    for (int unsigned i = 0; i < nbits; i++) begin
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'hd000_0001;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic string side_name(input bit side_b);
    return side_b ? "b" : "a";
  endfunction

  function automatic logic isolate_of(input bit side_b);
    return side_b ? b_isolate : a_isolate;
  endfunction

  function automatic logic clear_of(input bit side_b);
    return side_b ? b_clear : a_clear;
  endfunction

  // advance to the next falling edge of the chosen side's clock
  task automatic step_side(input bit side_b);
    if (side_b) begin
      @(negedge b_clk);
    end else begin
      @(negedge a_clk);
    end
  endtask

  // one-cycle clear strobe in the side's own domain
  task automatic strobe_clear(input bit side_b);
    step_side(side_b);
    if (side_b) b_clear_req = 1'b1;
    else a_clear_req = 1'b1;
    step_side(side_b);
    if (side_b) b_clear_req = 1'b0;
    else a_clear_req = 1'b0;
  endtask

  task automatic wait_isolate(input bit side_b, input logic level);
    int unsigned cycles;
    cycles = 0;
    step_side(side_b);
    while (isolate_of(side_b) !== level) begin
      if (cycles >= SEQ_TIMEOUT) begin
        report_failure($sformatf("timed out waiting for %s_isolate_o to become %0d",
                                 side_name(side_b), level));
      end
      step_side(side_b);
      cycles++;
    end
  endtask

  // both outputs of one side must stay low for the given number of cycles
  task automatic check_side_idle(input bit side_b, input int unsigned cycles);
    repeat (cycles) begin
      step_side(side_b);
      assert (isolate_of(side_b) === 1'b0) else
        report_failure($sformatf("[ERROR] %s_isolate_o = 0x%0h, expected 0x0",
                                 side_name(side_b), isolate_of(side_b)));
      assert (clear_of(side_b) === 1'b0) else
        report_failure($sformatf("[ERROR] %s_clear_o = 0x%0h, expected 0x0",
                                 side_name(side_b), clear_of(side_b)));
    end
  endtask

  task automatic expect_quiet(input int unsigned cycles);
    fork
      check_side_idle(1'b0, cycles);
      check_side_idle(1'b1, cycles);
    join
  endtask

  // a sequence has both isolates up, a clear pulse on each side, then both down
  task automatic run_to_completion();
    wait_isolate(1'b0, 1'b1);
    wait_isolate(1'b1, 1'b1);
    wait_isolate(1'b0, 1'b0);
    wait_isolate(1'b1, 1'b0);
    assert (a_clear_seen === 1'b1) else
      report_failure($sformatf("[ERROR] a_clear_o pulse seen = 0x%0h, expected 0x1",
                               a_clear_seen));
    assert (b_clear_seen === 1'b1) else
      report_failure($sformatf("[ERROR] b_clear_o pulse seen = 0x%0h, expected 0x1",
                               b_clear_seen));
    expect_quiet(QUIET_CYCLES);
  endtask

  // ------------------------------------------------------------
  // isolate acknowledge responders and clear monitors
  // ------------------------------------------------------------

  initial begin : a_responder
    int unsigned count;
    count = 0;
    forever begin
      @(negedge a_clk);
      if (!a_isolate) begin
        a_iso_ack = 1'b0;
        count     = 0;
      end else if (!a_iso_ack && !a_ack_hold) begin
        if (count >= a_ack_delay) a_iso_ack = 1'b1;
        else count++;
      end
    end
  end

  initial begin : b_responder
    int unsigned count;
    count = 0;
    forever begin
      @(negedge b_clk);
      if (!b_isolate) begin
        b_iso_ack = 1'b0;
        count     = 0;
      end else if (!b_iso_ack && !b_ack_hold) begin
        if (count >= b_ack_delay) b_iso_ack = 1'b1;
        else count++;
      end
    end
  end

  // clear may only ever be high under isolate, on either side
  always @(negedge a_clk) begin
    if (a_rst_n) begin
      assert (!a_clear || a_isolate) else
        report_failure($sformatf("[ERROR] a_clear_o = 0x%0h while a_isolate_o = 0x%0h",
                                 a_clear, a_isolate));
      if (a_clear) a_clear_seen = 1'b1;
    end
  end

  always @(negedge b_clk) begin
    if (b_rst_n) begin
      assert (!b_clear || b_isolate) else
        report_failure($sformatf("[ERROR] b_clear_o = 0x%0h while b_isolate_o = 0x%0h",
                                 b_clear, b_isolate));
      if (b_clear) b_clear_seen = 1'b1;
    end
  end

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------

  task automatic idle_after_reset();
    expect_quiet(50);
  endtask

  task automatic single_side_clear(input bit side_b);
    a_clear_seen = 1'b0;
    b_clear_seen = 1'b0;
    strobe_clear(side_b);
    run_to_completion();
  endtask

  // b holds back its isolate acknowledge, so no clear may start until it is released
  task automatic withheld_isolate_ack();
    b_ack_hold   = 1'b1;
    a_clear_seen = 1'b0;
    b_clear_seen = 1'b0;
    strobe_clear(1'b0);
    wait_isolate(1'b1, 1'b1);
    fork
      repeat (HOLD_CYCLES) begin
        @(negedge a_clk);
        assert (a_clear === 1'b0) else
          report_failure($sformatf("[ERROR] a_clear_o = 0x%0h, expected 0x0", a_clear));
      end
      repeat (HOLD_CYCLES) begin
        @(negedge b_clk);
        assert (b_clear === 1'b0) else
          report_failure($sformatf("[ERROR] b_clear_o = 0x%0h, expected 0x0", b_clear));
        assert (b_isolate === 1'b1) else
          report_failure($sformatf("[ERROR] b_isolate_o = 0x%0h, expected 0x1", b_isolate));
      end
    join
    b_ack_hold = 1'b0;
    run_to_completion();
  endtask

  task automatic simultaneous_clears();
    a_clear_seen = 1'b0;
    b_clear_seen = 1'b0;
    fork
      strobe_clear(1'b0);
      strobe_clear(1'b1);
    join
    run_to_completion();
  endtask

  task automatic back_to_back_sequences();
    bit          from_b;
    int unsigned gap;
    for (int unsigned i = 0; i < 20; i++) begin
      from_b      = 1'(random_bits(1));
      gap         = random_bits(4) + 2;
      a_ack_delay = random_bits(4);
      b_ack_delay = random_bits(4);
      repeat (gap) step_side(from_b);
      a_clear_seen = 1'b0;
      b_clear_seen = 1'b0;
      strobe_clear(from_b);
      run_to_completion();
    end
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------

  initial begin : main
    a_rst_n      = 1'b0;
    b_rst_n      = 1'b0;
    a_clear_req  = 1'b0;
    b_clear_req  = 1'b0;
    a_iso_ack    = 1'b0;
    b_iso_ack    = 1'b0;
    a_ack_hold   = 1'b0;
    b_ack_hold   = 1'b0;
    a_ack_delay  = 2;
    b_ack_delay  = 5;
    a_clear_seen = 1'b0;
    b_clear_seen = 1'b0;
    lfsr_state   = 32'hfa9;
    fork
      begin
        repeat (8) @(negedge a_clk);
        a_rst_n = 1'b1;
      end
      begin
        repeat (8) @(negedge b_clk);
        b_rst_n = 1'b1;
      end
    join
    idle_after_reset();
    single_side_clear(1'b0);
    single_side_clear(1'b1);
    withheld_isolate_ack();
    simultaneous_clears();
    back_to_back_sequences();
    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+hdl
hdl/clear_sync_pkg.sv
hdl/phase_cdc_src.sv
hdl/phase_cdc_dst.sv
hdl/clear_initiator.sv
hdl/clear_receiver.sv
hdl/clear_sync_half.sv
hdl/clear_sync.sv
tests/tb_clear_sync.sv

// ==== Bender.yml ====
package:
  name: clear_sync

dependencies: {}

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/clear_sync_pkg.sv
      - hdl/phase_cdc_src.sv
      - hdl/phase_cdc_dst.sv
      - hdl/clear_initiator.sv
      - hdl/clear_receiver.sv
      - hdl/clear_sync_half.sv
      - hdl/clear_sync.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_clear_sync.sv
